/* rtl/vram_display_config.svh */
// ---------------------------------------------------------------------------
// Video RAM and display configuration
// RAM size, FIFO depth and the (tiny) monochrome display timing
// ---------------------------------------------------------------------------
`ifndef VRAM_DISPLAY_CONFIG_SVH
`define VRAM_DISPLAY_CONFIG_SVH

// Word address width of the video RAM (16 words of 32 bits)
`define VRAM_ADDR_BITS 4

// Horizontal timing in clocks, one pixel per clock
`define H_ACTIVE 64
`define H_FRONT 4
`define H_SYNC 8
`define H_BACK 4
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 1
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Words shown per line and per frame
`define WORDS_PER_LINE (`H_ACTIVE / 32)
`define FRAME_WORDS (`WORDS_PER_LINE * `V_ACTIVE)

`define FIFO_DEPTH 4

`endif

/* rtl/vram_pkg.sv */
// ---------------------------------------------------------------------------
// Memory side types
// Processor request, RAM word and the VRAM controller states
// ---------------------------------------------------------------------------
`default_nettype none

`include "vram_display_config.svh"

package vram_pkg;

   // One word of video RAM, 32 pixels
   typedef logic [31:0] vram_word_t;

   // Processor command, held by the requester until cpu_ready
   typedef struct packed {
      logic [`VRAM_ADDR_BITS-1:0] addr;
      vram_word_t                 wdata;
      logic                       write;
   } cpu_req_t;

   // IDLE picks the next user of the single RAM port.
   // CPU_ACCESS is the second clock of a processor access,
   // FETCH reads one word for the display
   typedef enum logic [1:0] {
      IDLE,
      CPU_ACCESS,
      FETCH
   } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/video_pkg.sv */
// ---------------------------------------------------------------------------
// Video side types
// Sync and colour output bundle and the scan phase of a counter
// ---------------------------------------------------------------------------
`default_nettype none

package video_pkg;

   // VGA style output, syncs active low.
   // Monochrome, so the three colours carry the same pixel bit
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic red;
      logic green;
      logic blue;
   } video_out_t;

   // Phase of the horizontal or vertical counter, in scan order
   typedef enum logic [1:0] {
      ACTIVE,
      FRONT,
      SYNC,
      BACK
   } scan_phase_t;

endpackage

`default_nettype wire

/* rtl/vram_controller.sv */
// ---------------------------------------------------------------------------
// VRAM controller
// Owns the video RAM and shares its one port between processor accesses
// and display fetches, pushing fetched words into the line FIFO
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "vram_display_config.svh"

module vram_controller
   import vram_pkg::*;
(
   input  wire             clk,
   input  wire             reset,

   input  wire             cpu_req,
   input  wire cpu_req_t   cpu_cmd,
   output logic            cpu_ready,
   output logic            cpu_done,
   output vram_word_t      cpu_rdata,

   input  wire             frame_start,
   input  wire             full,
   output logic            push,
   output vram_word_t      push_data
);

   localparam logic [`VRAM_ADDR_BITS-1:0] FRAME_WORDS = `VRAM_ADDR_BITS'(`FRAME_WORDS);

   vram_word_t                 ram [2**`VRAM_ADDR_BITS];
   ctrl_state_t                state;
   cpu_req_t                   cmd_q;
   logic [`VRAM_ADDR_BITS-1:0] fetch_ptr;
   logic [`VRAM_ADDR_BITS-1:0] ram_addr;
   vram_word_t                 ram_rdata;
   logic                       accept;
   logic                       fetch_go;

   // Ready stays low from acceptance through the done pulse, so a requester
   // that drops cpu_req on seeing done is never accepted twice
   assign cpu_ready = (state == IDLE) && !cpu_done;
   assign accept    = cpu_req && cpu_ready;

   // A pending request, even one still waiting for ready, blocks fetching
   assign fetch_go = (state == IDLE) && !cpu_req && !full && (fetch_ptr < FRAME_WORDS);

   // The single RAM port. The display owns it only during FETCH
   assign ram_addr  = (state == FETCH) ? fetch_ptr : cmd_q.addr;
   assign ram_rdata = ram[ram_addr];

   // FETCH lasts one clock and is entered only with the FIFO not full,
   // and only pops can change the count meanwhile
   assign push      = (state == FETCH);
   assign push_data = ram_rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         cpu_done  <= 1'b0;
         // Nothing to fetch until the first vertical sync
         fetch_ptr <= FRAME_WORDS;
      end else begin
         cpu_done <= 1'b0;

         case (state)
            IDLE: begin
               if (accept) begin
                  state <= CPU_ACCESS;
               end else if (fetch_go) begin
                  state <= FETCH;
               end
            end
            CPU_ACCESS: begin
               cpu_done <= 1'b1;
               state    <= IDLE;
            end
            FETCH: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase

         if (frame_start) begin
            fetch_ptr <= '0;
         end else if (state == FETCH) begin
            fetch_ptr <= fetch_ptr + 1'b1;
         end
      end
   end

   // Command capture and the RAM access itself, done on the clock after
   // acceptance so the done pulse follows two clocks later
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= cpu_cmd;
      end
      if (state == CPU_ACCESS) begin
         if (cmd_q.write) begin
            ram[cmd_q.addr] <= cmd_q.wdata;
         end else begin
            cpu_rdata <= ram_rdata;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/line_fifo.sv */
// ---------------------------------------------------------------------------
// Line FIFO
// Small circular word buffer between the display fetch and the scan-out
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "vram_display_config.svh"

module line_fifo
   import vram_pkg::*;
(
   input  wire             clk,
   input  wire             reset,
   input  wire             push,
   input  wire vram_word_t push_data,
   input  wire             pop,
   output vram_word_t      pop_data,
   output logic            empty,
   output logic            full
);

   localparam int PTR_BITS = $clog2(`FIFO_DEPTH);
   localparam logic [PTR_BITS-1:0] LAST  = PTR_BITS'(`FIFO_DEPTH - 1);
   localparam logic [PTR_BITS:0]   DEPTH = (PTR_BITS + 1)'(`FIFO_DEPTH);

   vram_word_t          mem [`FIFO_DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [PTR_BITS:0]   count;
   logic                do_push;
   logic                do_pop;

   function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
      return (ptr == LAST) ? '0 : ptr + 1'b1;
   endfunction

   assign empty    = (count == '0);
   assign full     = (count == DEPTH);
   assign pop_data = mem[rd_ptr];

   // When full, a push alongside a pop reuses the slot being freed
   assign do_pop  = pop && !empty;
   assign do_push = push && (!full || do_pop);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

`default_nettype wire

/* rtl/vga_scanout.sv */
// ---------------------------------------------------------------------------
// VGA scan-out
// Sync counters and a pixel shifter that streams FIFO words to the display,
// blanking whole words and flagging underrun when the FIFO runs dry
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "vram_display_config.svh"

module vga_scanout
   import vram_pkg::*;
   import video_pkg::*;
(
   input  wire             clk,
   input  wire             reset,
   input  wire             empty,
   input  wire vram_word_t pop_data,
   output logic            pop,
   output logic            frame_start,
   output video_out_t      video,
   output logic            underrun
);

   localparam int H_BITS   = $clog2(`H_TOTAL);
   localparam int V_BITS   = $clog2(`V_TOTAL);
   localparam int WORD_LSB = $clog2($bits(vram_word_t));

   localparam logic [H_BITS-1:0] H_LAST  = H_BITS'(`H_TOTAL - 1);
   localparam logic [V_BITS-1:0] V_LAST  = V_BITS'(`V_TOTAL - 1);
   localparam logic [V_BITS-1:0] V_START = V_BITS'(`V_ACTIVE);

   logic [H_BITS-1:0] h_cnt;
   logic [V_BITS-1:0] v_cnt;
   scan_phase_t       h_phase;
   scan_phase_t       v_phase;
   logic              active_area;
   logic              word_start;
   logic              blank_now;
   logic              blank_q;
   logic              pixel;
   vram_word_t        pix_word;
   vram_word_t        shift_q;
   video_out_t        video_next;

   function automatic scan_phase_t phase_of(input int pos, input int n_active,
                                            input int n_front, input int n_sync);
      if (pos < n_active) begin
         return ACTIVE;
      end else if (pos < n_active + n_front) begin
         return FRONT;
      end else if (pos < n_active + n_front + n_sync) begin
         return SYNC;
      end
      return BACK;
   endfunction

   // Reset parks the scan at the start of the first vertical front porch line
   always_ff @(posedge clk) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= V_START;
      end else if (h_cnt == H_LAST) begin
         h_cnt <= '0;
         v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   assign h_phase = phase_of(int'(h_cnt), `H_ACTIVE, `H_FRONT, `H_SYNC);
   assign v_phase = phase_of(int'(v_cnt), `V_ACTIVE, `V_FRONT, `V_SYNC);

   assign active_area = (h_phase == ACTIVE) && (v_phase == ACTIVE);
   assign word_start  = active_area && (h_cnt[WORD_LSB-1:0] == '0);
   assign frame_start = (v_phase == SYNC) && (h_cnt == '0);
   assign pop         = word_start && !empty;

   // The first pixel of a word comes straight from the FIFO head,
   // the rest from the shifter, bit 0 first
   assign pix_word  = word_start ? pop_data : shift_q;
   assign blank_now = word_start ? empty : blank_q;
   assign pixel     = active_area && !blank_now && pix_word[0];

   always_comb begin
      video_next.hsync = (h_phase != SYNC);
      video_next.vsync = (v_phase != SYNC);
      video_next.red   = pixel;
      video_next.green = pixel;
      video_next.blue  = pixel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         video    <= '{hsync: 1'b1, vsync: 1'b1, default: 1'b0};
         blank_q  <= 1'b0;
         underrun <= 1'b0;
      end else begin
         video   <= video_next;
         blank_q <= blank_now;
         // Sticky until reset
         if (word_start && empty) begin
            underrun <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (active_area) begin
         shift_q <= pix_word >> 1;
      end
   end

endmodule

`default_nettype wire

/* rtl/vram_display_top.sv */
// ---------------------------------------------------------------------------
// Video display top level
// VRAM controller feeding the scan-out through the line FIFO
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vram_display_top
   import vram_pkg::*;
   import video_pkg::*;
(
   input  wire           clk,
   input  wire           reset,

   input  wire           cpu_req,
   input  wire cpu_req_t cpu_cmd,
   output logic          cpu_ready,
   output logic          cpu_done,
   output vram_word_t    cpu_rdata,

   output video_out_t    video,
   output logic          underrun
);

   logic       push;
   vram_word_t push_data;
   logic       full;
   logic       pop;
   vram_word_t pop_data;
   logic       empty;
   logic       frame_start;

   vram_controller vram_controller_inst (
      .clk         (clk),
      .reset       (reset),
      .cpu_req     (cpu_req),
      .cpu_cmd     (cpu_cmd),
      .cpu_ready   (cpu_ready),
      .cpu_done    (cpu_done),
      .cpu_rdata   (cpu_rdata),
      .frame_start (frame_start),
      .full        (full),
      .push        (push),
      .push_data   (push_data)
   );

   line_fifo line_fifo_inst (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .empty     (empty),
      .full      (full)
   );

   vga_scanout vga_scanout_inst (
      .clk         (clk),
      .reset       (reset),
      .empty       (empty),
      .pop_data    (pop_data),
      .pop         (pop),
      .frame_start (frame_start),
      .video       (video),
      .underrun    (underrun)
   );

endmodule

`default_nettype wire

/* tb/vram_display_assert.sv */
// ---------------------------------------------------------------------------
// Video display assertions
// Processor done pulse, FIFO push legality and horizontal sync placement
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vram_display_assert
   import video_pkg::*;
(
   input wire              clk,
   input wire              reset,
   input wire              cpu_done,
   input wire              push,
   input wire              full,
   input wire scan_phase_t h_phase,
   input wire              hsync
);

   int unsigned fail_count = 0;

   done_pulse: assert property (@(posedge clk) disable iff (reset)
      cpu_done |=> !cpu_done)
      else begin
         $error("cpu_done lasted more than one clock");
         fail_count++;
      end

   no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      push |-> !full)
      else begin
         $error("push while the line FIFO is full");
         fail_count++;
      end

   // Video is registered, so the sync phase shows one clock later
   hsync_in_sync: assert property (@(posedge clk) disable iff (reset)
      !hsync |-> $past(h_phase) == SYNC)
      else begin
         $error("hsync low outside the horizontal sync phase");
         fail_count++;
      end

endmodule

bind vram_controller vram_display_assert ctrl_assert_inst (
   .clk (clk), .reset (reset), .cpu_done (cpu_done),
   .push (push), .full (full), .h_phase (video_pkg::SYNC), .hsync (1'b1)
);

bind vga_scanout vram_display_assert scan_assert_inst (
   .clk (clk), .reset (reset), .cpu_done (1'b0),
   .push (1'b0), .full (1'b0), .h_phase (h_phase), .hsync (video.hsync)
);

`default_nettype wire

/* tb/vram_display_tb.sv */
// ---------------------------------------------------------------------------
// Video display testbench
// Directed tests of the processor port, frame contents, sync and underrun
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "vram_display_config.svh"

module vram_display_tb
   import vram_pkg::*;
   import video_pkg::*;
();

   localparam int TIMEOUT   = 2000;
   localparam int SIG_READY = 0;
   localparam int SIG_DONE  = 1;
   localparam int SIG_HSYNC = 2;
   localparam int SIG_VSYNC = 3;
   localparam video_out_t BLANK = '{hsync: 1'b1, vsync: 1'b1, default: 1'b0};

   logic       clk = 1'b0;
   logic       reset = 1'b1;
   logic       cpu_req = 1'b0;
   cpu_req_t   cpu_cmd = '0;
   logic       cpu_ready;
   logic       cpu_done;
   vram_word_t cpu_rdata;
   video_out_t video;
   logic       underrun;
   vram_word_t ref_ram [2**`VRAM_ADDR_BITS];

   vram_display_top vram_display_top_inst (
      .clk       (clk),
      .reset     (reset),
      .cpu_req   (cpu_req),
      .cpu_cmd   (cpu_cmd),
      .cpu_ready (cpu_ready),
      .cpu_done  (cpu_done),
      .cpu_rdata (cpu_rdata),
      .video     (video),
      .underrun  (underrun)
   );

   always #4 clk = ~clk;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
   endtask

   function automatic int unsigned assertion_failures();
      return vram_display_top_inst.vram_controller_inst.ctrl_assert_inst.fail_count
             + vram_display_top_inst.vga_scanout_inst.scan_assert_inst.fail_count;
   endfunction

   always @(negedge clk) begin
      if (assertion_failures() != 0) begin
         stop_with_failure("A bound assertion failed");
      end
   end

   task automatic check_word(input string name, input vram_word_t exp, input vram_word_t act);
      if (act !== exp) begin
         stop_with_failure($sformatf("** Error [%s] expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_video(input string name, input video_out_t exp, input video_out_t act);
      if (act !== exp) begin
         stop_with_failure($sformatf("** Error [%s] expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_with_failure($sformatf("** Error [%s] expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         stop_with_failure($sformatf("** Error [%s] expected %0d, actual %0d", name, exp, act));
      end
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         SIG_READY: return cpu_ready;
         SIG_DONE:  return cpu_done;
         SIG_HSYNC: return video.hsync;
         default:   return video.vsync;
      endcase
   endfunction

   // Counts falling edges until the probed signal reaches the level
   task automatic wait_level(input int sel, input logic level, input string what, output int n);
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (probe(sel) !== level && n < TIMEOUT);
      if (probe(sel) !== level) begin
         stop_with_failure({"Timed out waiting for ", what});
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
   endtask

   task automatic ram_access(input string name, input logic is_write,
                             input logic [`VRAM_ADDR_BITS-1:0] word_addr,
                             input vram_word_t data, output vram_word_t rdata);
      int n;
      @(posedge clk);
      cpu_req <= 1'b1;
      cpu_cmd <= '{addr: word_addr, wdata: data, write: is_write};
      wait_level(SIG_READY, 1'b1, "cpu_ready", n);
      // The next rising edge accepts the command
      @(posedge clk);
      wait_level(SIG_DONE, 1'b1, "cpu_done", n);
      check_count({name, " done latency"}, 2, n);
      rdata = cpu_rdata;
      @(posedge clk);
      cpu_req <= 1'b0;
   endtask

   task automatic write_word(input string name, input logic [`VRAM_ADDR_BITS-1:0] word_addr,
                             input vram_word_t data);
      vram_word_t unused;
      ram_access(name, 1'b1, word_addr, data, unused);
      ref_ram[word_addr] = data;
   endtask

   task automatic read_word(input string name, input logic [`VRAM_ADDR_BITS-1:0] word_addr);
      vram_word_t rdata;
      ram_access(name, 1'b0, word_addr, '0, rdata);
      check_word($sformatf("%s addr %0d", name, word_addr), ref_ram[word_addr], rdata);
   endtask

   task automatic wait_vsync_rise();
      int n;
      wait_level(SIG_VSYNC, 1'b1, "vsync high", n);
      wait_level(SIG_VSYNC, 1'b0, "vsync fall", n);
      wait_level(SIG_VSYNC, 1'b1, "vsync rise", n);
   endtask

   // Lines below good_lines show their two words, the rest must be black
   task automatic capture_frame(input string name, input int good_lines);
      video_out_t exp;
      logic       pix;
      int         line;
      int         x;
      wait_vsync_rise();
      repeat (`H_TOTAL * `V_BACK) @(negedge clk);
      for (line = 0; line < `V_ACTIVE; line++) begin
         for (x = 0; x < `H_TOTAL; x++) begin
            if (x < `H_ACTIVE) begin
               pix = (line < good_lines) && ref_ram[line * `WORDS_PER_LINE + x / 32][x % 32];
               exp = '{hsync: 1'b1, vsync: 1'b1, red: pix, green: pix, blue: pix};
               check_video($sformatf("%s line %0d pixel %0d", name, line, x), exp, video);
            end
            @(negedge clk);
         end
      end
   endtask

   task automatic measure_sync(input int sel, output int low_w, output int period);
      int n;
      wait_level(sel, 1'b1, "sync high", n);
      wait_level(sel, 1'b0, "sync fall", n);
      wait_level(sel, 1'b1, "sync rise", low_w);
      wait_level(sel, 1'b0, "next sync fall", n);
      period = low_w + n;
   endtask

   task automatic test_reset_state();
      check_flag("reset_state ready", 1'b1, cpu_ready);
      check_flag("reset_state done", 1'b0, cpu_done);
      check_video("reset_state video", BLANK, video);
      check_flag("reset_state underrun", 1'b0, underrun);
   endtask

   task automatic test_write_read();
      for (int a = 0; a < 2**`VRAM_ADDR_BITS; a++) begin
         write_word("write_read", `VRAM_ADDR_BITS'(a), $urandom());
      end
      for (int a = 0; a < 2**`VRAM_ADDR_BITS; a++) begin
         read_word("write_read", `VRAM_ADDR_BITS'(a));
      end
   endtask

   task automatic test_frame_contents();
      for (int a = 0; a < `FRAME_WORDS; a++) begin
         write_word("frame_contents", `VRAM_ADDR_BITS'(a), $urandom());
      end
      capture_frame("frame_contents", `V_ACTIVE);
      check_flag("frame_contents underrun", 1'b0, underrun);
   endtask

   task automatic test_sync_timing();
      int low_w;
      int period;
      measure_sync(SIG_HSYNC, low_w, period);
      check_count("sync_timing hsync low", `H_SYNC, low_w);
      check_count("sync_timing hsync period", `H_TOTAL, period);
      measure_sync(SIG_VSYNC, low_w, period);
      check_count("sync_timing vsync low", `H_TOTAL * `V_SYNC, low_w);
      check_count("sync_timing vsync period", `H_TOTAL * `V_TOTAL, period);
   endtask

   task automatic test_underrun();
      // Start holding the port in the front porch line, before any fetch
      wait_vsync_rise();
      repeat (`H_TOTAL * (`V_BACK + `V_ACTIVE)) @(posedge clk);
      cpu_req <= 1'b1;
      cpu_cmd <= '{addr: '0, wdata: '0, write: 1'b0};
      capture_frame("underrun", 0);
      check_flag("underrun set", 1'b1, underrun);
      @(posedge clk);
      cpu_req <= 1'b0;
      wait_vsync_rise();
      // Words are on hand again through these active lines
      repeat (`H_TOTAL * (`V_BACK + `V_ACTIVE)) @(negedge clk);
      check_flag("underrun sticky", 1'b1, underrun);
      apply_reset();
      check_flag("underrun cleared", 1'b0, underrun);
      capture_frame("underrun recovery", `V_ACTIVE);
      check_flag("underrun recovery flag", 1'b0, underrun);
   endtask

   initial begin
      void'($urandom(32'h8e18_a163));
      apply_reset();
      test_reset_state();
      test_write_read();
      test_frame_contents();
      test_sync_timing();
      test_underrun();
      if (assertion_failures() != 0) begin
         stop_with_failure("A bound assertion failed");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/vram_pkg.sv
rtl/video_pkg.sv
rtl/vram_controller.sv
rtl/line_fifo.sv
rtl/vga_scanout.sv
rtl/vram_display_top.sv
tb/vram_display_assert.sv
tb/vram_display_tb.sv
